// ==== sources.f ====
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/hazardUnit.sv
design/processor.sv
dv/processorChk.sv
dv/processorTb.sv

// ==== Bender.yml ====
package:
  name: processor

sources:
  - design/cpuPkg.sv
  - design/fetchStage.sv
  - design/decodeStage.sv
  - design/executeStage.sv
  - design/hazardUnit.sv
  - design/processor.sv
  - target: test
    files:
      - dv/processorChk.sv
      - dv/processorTb.sv

// ==== dv/processorTb.sv ====
// ------------------------------
// Random program testbench for the five-stage core
// Program words 0..58 are random and word 59 is a self-branch halt
// Data memory has 64 words, writes at the edge and registers its read data
// Loads and stores are aimed inside data memory when generated
// ------------------------------

`timescale 1ns/10ps

module processorTb;

    localparam int AddrWidth = 16;
    localparam int HaltAddr  = 59;
    localparam int MemWords  = 64;
    localparam int Timeout   = 2000;

    localparam logic [5:0] OpRType = 6'd0;
    localparam logic [5:0] OpBeq   = 6'd4;
    localparam logic [5:0] OpBne   = 6'd5;
    localparam logic [5:0] OpAddi  = 6'd8;
    localparam logic [5:0] OpLw    = 6'd35;
    localparam logic [5:0] OpSw    = 6'd43;
    localparam logic [5:0] FuncCodes [5] = '{6'd32, 6'd34, 6'd36, 6'd37, 6'd42};

    logic                 Clock = 1'b0;
    logic                 nReset;
    logic [31:0]          InstrMem;
    logic [31:0]          MemData;
    logic [4:0]           RegAddr;
    logic [AddrWidth-1:0] InstrAddr;
    logic [AddrWidth-1:0] MemAddr;
    logic [31:0]          WriteData;
    logic [31:0]          RegData;
    logic                 MemWrite;
    logic                 MemRead;
    logic                 nStall;

    logic [31:0] rom [0:MemWords-1];
    logic [31:0] dataMem [0:MemWords-1];
    logic [31:0] modelMem [0:MemWords-1];
    logic [31:0] modelRegs [0:31];
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    logic [31:0] loadAddrQ [$];
    logic [31:0] rngState;
    logic [4:0]  lastLoadDest;
    int          stallPairs;
    int          stallCycles = 0;
    int          storesSeen = 0;
    int          loadsSeen = 0;
    int          monitorErrors = 0;
    int          mainErrors;
    int          totalErrors;

    always #10 Clock = ~Clock;

    processor #(.AddrWidth(AddrWidth)) i_processor (
        .Clock    (Clock),
        .nReset   (nReset),
        .InstrMem (InstrMem),
        .MemData  (MemData),
        .RegAddr  (RegAddr),
        .InstrAddr(InstrAddr),
        .MemAddr  (MemAddr),
        .WriteData(WriteData),
        .RegData  (RegData),
        .MemWrite (MemWrite),
        .MemRead  (MemRead),
        .nStall   (nStall)
    );

    // Instruction ROM answers in the same cycle
    assign InstrMem = (InstrAddr < MemWords) ? rom[InstrAddr[5:0]] : 32'd0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift(rngState);
        return int'(rngState % n);
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'(1 + randBelow(7));
    endfunction

    function automatic logic [31:0] fillWord(input int a);
        return 32'(a) * 32'd5 + 32'd3;
    endfunction

    // ISA reference model ----------
    task automatic interpret(input logic [31:0] word, inout int pc);
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic        readsRt;
        op      = word[31:26];
        rs      = word[25:21];
        rt      = word[20:16];
        rd      = word[15:11];
        imm     = {{16{word[15]}}, word[15:0]};
        a       = modelRegs[rs];
        b       = modelRegs[rt];
        readsRt = (op == OpRType || op == OpSw || op == OpBeq || op == OpBne);
        // Load directly followed by a reader of its result
        if (lastLoadDest != 5'd0 &&
            (rs == lastLoadDest || (readsRt && rt == lastLoadDest)))
            stallPairs++;
        lastLoadDest = (op == OpLw) ? rt : 5'd0;
        addr = a + imm;
        pc   = pc + 1;
        case (op)
            OpRType: begin
                case (word[5:0])
                    6'd32:   modelRegs[rd] = a + b;
                    6'd34:   modelRegs[rd] = a - b;
                    6'd36:   modelRegs[rd] = a & b;
                    6'd37:   modelRegs[rd] = a | b;
                    default: modelRegs[rd] = {31'd0, $signed(a) < $signed(b)};
                endcase
            end
            OpAddi: modelRegs[rt] = addr;
            OpLw: begin
                loadAddrQ.push_back(addr);
                modelRegs[rt] = modelMem[addr[5:0]];
            end
            OpSw: begin
                storeAddrQ.push_back(addr);
                storeDataQ.push_back(b);
                modelMem[addr[5:0]] = b;
            end
            OpBeq: if (a == b) pc = pc + int'($signed(imm));
            OpBne: if (a != b) pc = pc + int'($signed(imm));
            default: ;
        endcase
        modelRegs[0] = '0;
    endtask

    // Program generation runs the model alongside, so addresses can be aimed
    task automatic buildProgram();
        int          pc;
        int          kind;
        int          off;
        int          target;
        int          baseVal;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] word;
        rngState     = 32'd86;
        lastLoadDest = 5'd0;
        stallPairs   = 0;
        for (int a = 0; a < MemWords; a++) begin
            rom[a]      = '0;
            modelMem[a] = fillWord(a);
        end
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        pc = 0;
        for (int i = 0; i < HaltAddr; i++) begin
            kind = randBelow(10);
            rs   = pickReg();
            rt   = pickReg();
            rd   = pickReg();
            imm  = 16'(randBelow(64)) - 16'd32;
            if (kind < 4) begin
                word = {OpRType, rs, rt, rd, 5'd0, FuncCodes[randBelow(5)]};
            end else if (kind < 6) begin
                word = {OpAddi, rs, rt, imm};
            end else if (kind < 9) begin
                target  = randBelow(MemWords);
                baseVal = $signed(modelRegs[rs]);
                // Skipped slots and far-off bases fall back to r0
                if (i != pc || baseVal < -32000 || baseVal > 32000) begin
                    rs      = 5'd0;
                    baseVal = 0;
                end
                imm  = 16'(target - baseVal);
                word = {(kind < 8) ? OpLw : OpSw, rs, rt, imm};
            end else begin
                off = randBelow(4);
                if (i + 1 + off > HaltAddr)
                    off = HaltAddr - 1 - i;
                word = {(randBelow(2) == 0) ? OpBeq : OpBne, rs, rt, 16'(off)};
            end
            rom[i] = word;
            if (i == pc)
                interpret(word, pc);
        end
        rom[HaltAddr] = {OpBeq, 5'd0, 5'd0, 16'hFFFF};
    endtask

    // Data memory ------------------
    initial begin
        logic        doWrite;
        logic        doRead;
        logic [5:0]  index;
        logic [31:0] storeWord;
        for (int a = 0; a < MemWords; a++) begin
            dataMem[a] = fillWord(a);
        end
        MemData = '0;
        forever begin
            @(negedge Clock);
            doWrite   = MemWrite;
            doRead    = MemRead;
            index     = MemAddr[5:0];
            storeWord = WriteData;
            @(posedge Clock);
            #2;
            if (doWrite)
                dataMem[index] = storeWord;
            if (doRead)
                MemData = dataMem[index];
        end
    end

    // Data port and stall monitor
    always @(negedge Clock) begin
        if (nReset) begin
            if (!nStall)
                stallCycles++;
            if (MemWrite) begin
                if (storesSeen >= storeAddrQ.size()) begin
                    $display("Fail at %0d ns: extra store of %h to %h", $time, WriteData,
                             MemAddr);
                    monitorErrors++;
                end else if (32'(MemAddr) !== storeAddrQ[storesSeen] ||
                             WriteData !== storeDataQ[storesSeen]) begin
                    $display("Fail at %0d ns: store %0d wrote %h to %h, expected %h to %h",
                             $time, storesSeen, WriteData, MemAddr,
                             storeDataQ[storesSeen], storeAddrQ[storesSeen]);
                    monitorErrors++;
                end
                storesSeen++;
            end
            if (MemRead) begin
                if (loadsSeen >= loadAddrQ.size()) begin
                    $display("Fail at %0d ns: extra load from %h", $time, MemAddr);
                    monitorErrors++;
                end else if (32'(MemAddr) !== loadAddrQ[loadsSeen]) begin
                    $display("Fail at %0d ns: load %0d from %h, expected %h",
                             $time, loadsSeen, MemAddr, loadAddrQ[loadsSeen]);
                    monitorErrors++;
                end
                loadsSeen++;
            end
        end
    end

    // Main sequence ----------------
    initial begin
        int cycles;
        mainErrors = 0;
        nReset     = 1'b0;
        RegAddr    = 5'd0;
        buildProgram();
        repeat (16) @(posedge Clock);
        #2 nReset = 1'b1;
        @(negedge Clock);
        if (InstrAddr !== '0 || MemWrite !== 1'b0 || MemRead !== 1'b0 || nStall !== 1'b1) begin
            $display("Fail at %0d ns: after reset InstrAddr=%h MemWrite=%b MemRead=%b nStall=%b",
                     $time, InstrAddr, MemWrite, MemRead, nStall);
            mainErrors++;
        end
        // Fetch of halt+2 means the halt itself is in execute
        cycles = 0;
        while (InstrAddr !== AddrWidth'(HaltAddr + 2) && cycles < Timeout) begin
            @(negedge Clock);
            cycles++;
        end
        if (InstrAddr !== AddrWidth'(HaltAddr + 2)) begin
            $display("Timeout: the core did not reach the halt loop within %0d cycles",
                     Timeout);
            mainErrors++;
        end else begin
            // Let memory and writeback drain
            repeat (2) @(posedge Clock);
            for (int r = 0; r < 8; r++) begin
                #2 RegAddr = 5'(r);
                @(negedge Clock);
                if (RegData !== modelRegs[r]) begin
                    $display("Fail at %0d ns: r%0d reads %h, expected %h",
                             $time, r, RegData, modelRegs[r]);
                    mainErrors++;
                end
                @(posedge Clock);
            end
        end
        if (storesSeen != storeAddrQ.size()) begin
            $display("Fail at %0d ns: %0d stores seen, expected %0d",
                     $time, storesSeen, storeAddrQ.size());
            mainErrors++;
        end
        if (loadsSeen != loadAddrQ.size()) begin
            $display("Fail at %0d ns: %0d loads seen, expected %0d",
                     $time, loadsSeen, loadAddrQ.size());
            mainErrors++;
        end
        if (stallCycles != stallPairs) begin
            $display("Fail at %0d ns: %0d stall cycles, expected %0d",
                     $time, stallCycles, stallPairs);
            mainErrors++;
        end
        totalErrors = mainErrors + monitorErrors + i_processor.i_processorChk.failCount;
        $display("Done: %0d stores, %0d loads, %0d stalls, %0d check errors, %0d assertion errors",
                 storesSeen, loadsSeen, stallCycles, mainErrors + monitorErrors,
                 i_processor.i_processorChk.failCount);
        if (totalErrors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== dv/processorChk.sv ====
// ------------------------------
// Port assertions for the core, bound into processor
// Checked only while nReset is high
// ------------------------------

`timescale 1ns/10ps

module processorChk #(
    parameter int AddrWidth = 16
) (
    input logic                 Clock,
    input logic                 nReset,
    input logic [AddrWidth-1:0] InstrAddr,
    input logic                 MemRead,
    input logic                 MemWrite,
    input logic                 nStall,
    input logic                 branchTaken
);

    int failCount = 0;

    memPortExclusive: assert property (@(posedge Clock) disable iff (!nReset)
        !(MemRead && MemWrite))
        else begin
            failCount++;
            $error("MemRead and MemWrite high in the same cycle");
        end

    // Load-use costs exactly one cycle
    singleStall: assert property (@(posedge Clock) disable iff (!nReset)
        !nStall |=> nStall)
        else begin
            failCount++;
            $error("nStall low for two cycles in a row");
        end

    pcHoldsOnStall: assert property (@(posedge Clock) disable iff (!nReset)
        (!nStall && !branchTaken) |=> $stable(InstrAddr))
        else begin
            failCount++;
            $error("InstrAddr moved during a stall cycle");
        end

endmodule

bind processor processorChk #(.AddrWidth(AddrWidth)) i_processorChk (
    .Clock      (Clock),
    .nReset     (nReset),
    .InstrAddr  (InstrAddr),
    .MemRead    (MemRead),
    .MemWrite   (MemWrite),
    .nStall     (nStall),
    .branchTaken(branchTaken)
);

// ==== design/processor.sv ====
// ----------------------------
// Five-stage in-order core, no delay slot
// InstrMem must answer InstrAddr combinationally
// MemData is expected one cycle after MemRead
// Taken branch squashes the two younger entries
// ----------------------------

`timescale 1ns/10ps

module processor #(
    parameter int AddrWidth = 16
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  logic [31:0]          InstrMem,
    input  logic [31:0]          MemData,
    input  logic [4:0]           RegAddr,
    output logic [AddrWidth-1:0] InstrAddr,
    output logic [AddrWidth-1:0] MemAddr,
    output logic [31:0]          WriteData,
    output logic [31:0]          RegData,
    output logic                 MemWrite,
    output logic                 MemRead,
    output logic                 nStall
);
    import cpuPkg::*;

    instrT                fdInstr;
    logic [AddrWidth-1:0] fdPc;
    decExT                decNext;
    decExT                decEx;
    exMemT                exMem;
    memWbT                memWb;
    logic [1:0]           fwdA;
    logic [1:0]           fwdB;
    logic [31:0]          opA;
    logic [31:0]          opB;
    logic [31:0]          aluResult;
    logic [31:0]          wbData;
    logic                 branchTaken;
    logic [AddrWidth-1:0] branchTarget;

    fetchStage #(.AddrWidth(AddrWidth)) i_fetchStage (
        .Clock       (Clock),
        .nReset      (nReset),
        .nStall      (nStall),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .InstrAddr   (InstrAddr)
    );

    // Fetch/decode ----------------
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            fdInstr <= '0;
            fdPc    <= '0;
        end else if (branchTaken) begin
            fdInstr <= '0;
        end else if (nStall) begin
            fdInstr <= InstrMem;
            fdPc    <= InstrAddr;
        end
    end

    decodeStage i_decodeStage (
        .Clock  (Clock),
        .nReset (nReset),
        .instr  (fdInstr),
        .pc     (32'(fdPc)),
        .wbWrite(memWb.regWrite),
        .wbAddr (memWb.destAddr),
        .wbData (wbData),
        .RegAddr(RegAddr),
        .RegData(RegData),
        .decOut (decNext)
    );

    hazardUnit i_hazardUnit (
        .decRs      (decNext.rsAddr),
        .decRt      (decNext.rtAddr),
        .exRs       (decEx.rsAddr),
        .exRt       (decEx.rtAddr),
        .exMemRead  (decEx.ctrl.memRead),
        .exDest     (decEx.destAddr),
        .memDest    (exMem.destAddr),
        .memRegWrite(exMem.ctrl.regWrite),
        .wbDest     (memWb.destAddr),
        .wbRegWrite (memWb.regWrite),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .nStall     (nStall)
    );

    // Decode/execute, bubble on squash or stall
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            decEx <= '0;
        else if (branchTaken || !nStall)
            decEx <= '0;
        else
            decEx <= decNext;
    end

    // Forwarding muxes ------------
    always_comb begin
        case (fwdA)
            2'd1:    opA = exMem.aluResult;
            2'd2:    opA = wbData;
            default: opA = decEx.rsData;
        endcase
        case (fwdB)
            2'd1:    opB = exMem.aluResult;
            2'd2:    opB = wbData;
            default: opB = decEx.rtData;
        endcase
    end

    executeStage #(.AddrWidth(AddrWidth)) i_executeStage (
        .decIn       (decEx),
        .opA         (opA),
        .opB         (opB),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    // Execute/memory and memory/writeback
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            exMem <= '0;
            memWb <= '0;
        end else begin
            exMem.ctrl      <= decEx.ctrl;
            exMem.destAddr  <= decEx.destAddr;
            exMem.aluResult <= aluResult;
            exMem.storeData <= opB;
            memWb.regWrite  <= exMem.ctrl.regWrite;
            memWb.memToReg  <= exMem.ctrl.memToReg;
            memWb.destAddr  <= exMem.destAddr;
            memWb.aluResult <= exMem.aluResult;
        end
    end

    // Data port
    assign MemAddr   = exMem.aluResult[AddrWidth-1:0];
    assign WriteData = exMem.storeData;
    assign MemWrite  = exMem.ctrl.memWrite;
    assign MemRead   = exMem.ctrl.memRead;

    assign wbData = memWb.memToReg ? MemData : memWb.aluResult;

endmodule

// ==== design/hazardUnit.sv ====
// ----------------------------
// Forwarding selects and load-use stall
// Select 1 is memory stage, 2 is writeback
// Register 0 never forwards or stalls
// ----------------------------

`timescale 1ns/10ps

module hazardUnit (
    input  logic [4:0] decRs,
    input  logic [4:0] decRt,
    input  logic [4:0] exRs,
    input  logic [4:0] exRt,
    input  logic       exMemRead,
    input  logic [4:0] exDest,
    input  logic [4:0] memDest,
    input  logic       memRegWrite,
    input  logic [4:0] wbDest,
    input  logic       wbRegWrite,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB,
    output logic       nStall
);

    function automatic logic [1:0] fwdSelect(input logic [4:0] src);
        logic [1:0] sel;
        sel = 2'd0;
        if (src != 5'd0) begin
            // Youngest producer wins
            if (memRegWrite && memDest == src)
                sel = 2'd1;
            else if (wbRegWrite && wbDest == src)
                sel = 2'd2;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = fwdSelect(exRs);
        fwdB = fwdSelect(exRt);
    end

    // Load data is only ready in writeback
    assign nStall = !(exMemRead && exDest != 5'd0 &&
                      (exDest == decRs || exDest == decRt));

endmodule

// ==== design/executeStage.sv ====
// ----------------------------
// ALU and branch resolution
// Operands arrive already forwarded
// Branch target is pc + 1 + imm, truncated to AddrWidth
// ----------------------------

`timescale 1ns/10ps

module executeStage #(
    parameter int AddrWidth = 16
) (
    input  cpuPkg::decExT        decIn,
    input  logic [31:0]          opA,
    input  logic [31:0]          opB,
    output logic [31:0]          aluResult,
    output logic                 branchTaken,
    output logic [AddrWidth-1:0] branchTarget
);
    import cpuPkg::*;

    logic [31:0] aluB;
    logic [31:0] targetFull;
    logic        operandsEqual;

    assign aluB = decIn.ctrl.aluSrc ? decIn.imm : opB;

    always_comb begin
        case (decIn.aluOp)
            Sub:     aluResult = opA - aluB;
            And:     aluResult = opA & aluB;
            Or:      aluResult = opA | aluB;
            Slt:     aluResult = {31'b0, $signed(opA) < $signed(aluB)};
            default: aluResult = opA + aluB;
        endcase
    end

    // Branches ----------------------
    assign operandsEqual = (opA == opB);

    // Only a decoded branch can redirect
    assign branchTaken = decIn.ctrl.branch &&
                         (decIn.ctrl.branchNe ? !operandsEqual : operandsEqual);

    assign targetFull   = decIn.pc + 32'd1 + decIn.imm;
    assign branchTarget = targetFull[AddrWidth-1:0];

endmodule

// ==== design/decodeStage.sv ====
// ----------------------------
// Decoder and register file
// Writeback is visible to reads in the same cycle
// Unknown opcodes and functions decode as bubbles
// ----------------------------

`timescale 1ns/10ps

module decodeStage (
    input  logic          Clock,
    input  logic          nReset,
    input  cpuPkg::instrT instr,
    input  logic [31:0]   pc,
    input  logic          wbWrite,
    input  logic [4:0]    wbAddr,
    input  logic [31:0]   wbData,
    input  logic [4:0]    RegAddr,
    output logic [31:0]   RegData,
    output cpuPkg::decExT decOut
);
    import cpuPkg::*;

    logic [31:0] regs [1:31];
    ctrlT        ctrl;
    aluOpT       aluOp;
    logic        valid;
    logic        readsRt;
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;

    function automatic logic [31:0] readReg(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0)
            value = '0;
        else if (wbWrite && wbAddr == addr)
            value = wbData;
        else
            value = regs[addr];
        return value;
    endfunction

    // Control decode --------------
    always_comb begin
        ctrl    = '0;
        aluOp   = Add;
        valid   = 1'b1;
        readsRt = 1'b0;
        case (instr.r.opcode)
            RTYPE: begin
                ctrl.regWrite = 1'b1;
                readsRt       = 1'b1;
                case (instr.r.func)
                    ADD:     aluOp = Add;
                    SUB:     aluOp = Sub;
                    AND:     aluOp = And;
                    OR:      aluOp = Or;
                    SLT:     aluOp = Slt;
                    default: valid = 1'b0;
                endcase
            end
            ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                readsRt       = 1'b1;
            end
            BEQ, BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (instr.r.opcode == BNE);
                aluOp         = Sub;
                readsRt       = 1'b1;
            end
            default: valid = 1'b0;
        endcase
    end

    // rt only counts as a source when it is really read
    assign rsAddr = valid ? instr.i.rs : 5'd0;
    assign rtAddr = (valid && readsRt) ? instr.i.rt : 5'd0;

    always_comb begin
        decOut = '0;
        if (valid) begin
            decOut.ctrl     = ctrl;
            decOut.aluOp    = aluOp;
            decOut.destAddr = (instr.r.opcode == RTYPE) ? instr.r.rd : instr.i.rt;
            decOut.imm      = {{16{instr.i.imm[15]}}, instr.i.imm};
            decOut.pc       = pc;
        end
        decOut.rsAddr = rsAddr;
        decOut.rtAddr = rtAddr;
        decOut.rsData = readReg(rsAddr);
        decOut.rtData = readReg(rtAddr);
    end

    always_comb begin
        RegData = readReg(RegAddr);
    end

    // Register file ---------------
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite && wbAddr != 5'd0) begin
            regs[wbAddr] <= wbData;
        end
    end

endmodule

// ==== design/fetchStage.sv ====
// ----------------------------
// Program counter, word addressed
// Branch redirect wins over stall
// ----------------------------

`timescale 1ns/10ps

module fetchStage #(
    parameter int AddrWidth = 16
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  logic                 nStall,
    input  logic                 branchTaken,
    input  logic [AddrWidth-1:0] branchTarget,
    output logic [AddrWidth-1:0] InstrAddr
);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            InstrAddr <= '0;
        end else if (branchTaken) begin
            InstrAddr <= branchTarget;
        end else if (nStall) begin
            InstrAddr <= InstrAddr + 1'b1;
        end
        // Stalled, hold the PC
    end

endmodule

// ==== design/cpuPkg.sv ====
// ----------------------------
// Shared types for the five-stage core
// All-zero instrT decodes as a bubble
// Word addressing throughout
// ----------------------------

package cpuPkg;

    typedef enum logic [5:0] {
        RTYPE = 6'd0,
        BEQ   = 6'd4,
        BNE   = 6'd5,
        ADDI  = 6'd8,
        LW    = 6'd35,
        SW    = 6'd43
    } opcodeT;

    typedef enum logic [5:0] {
        ADD = 6'd32,
        SUB = 6'd34,
        AND = 6'd36,
        OR  = 6'd37,
        SLT = 6'd42
    } funcT;

    typedef enum logic [2:0] {
        Add,
        Sub,
        And,
        Or,
        Slt
    } aluOpT;

    // Instruction formats ---------
    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funcT        func;
    } rTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    // Same word, two views
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

    // Pipeline contents -----------
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrc;
        logic branch;
        logic branchNe;
    } ctrlT;

    typedef struct packed {
        ctrlT        ctrl;
        aluOpT       aluOp;
        logic [4:0]  rsAddr;
        logic [4:0]  rtAddr;
        logic [4:0]  destAddr;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;
        logic [31:0] pc;
    } decExT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [4:0]  destAddr;
        logic [31:0] aluResult;
        logic [31:0] storeData;
    } exMemT;

    typedef struct packed {
        logic        regWrite;
        logic        memToReg;
        logic [4:0]  destAddr;
        logic [31:0] aluResult;
    } memWbT;

endpackage
